//--- axi_wr_master.f
rtl/axi_pkg.sv
rtl/wr_ctrl_pkg.sv
rtl/wr_order_fifo.sv
rtl/wr_slot_table.sv
rtl/wr_burst_addr_gen.sv
rtl/wr_data_channel.sv
rtl/axi_wr_master.sv
verification/wr_master_assert.sv
verification/wr_master_checker.sv
verification/tb_axi_wr_master.sv

//--- run_sim.sh
#!/bin/sh
# Build the axi_wr_master testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f axi_wr_master.f --top-module tb_axi_wr_master -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"
exit 0

//--- verification/wr_cases.txt
# Columns in hex: addr len size burst(0 FIXED 1 INCR 2 WRAP) beats last_addr resp(0 OKAY 2 SLVERR)
# One write command per line
0100 3 2 1 4 010C 0
0200 0 2 1 1 0200 0
0304 7 2 1 8 0320 0
0400 3 2 0 4 0400 0
0408 3 2 2 4 0404 2
0510 7 2 2 8 050C 0
0602 3 1 1 4 0608 0
0703 2 2 1 3 0708 0
0800 1 0 1 2 0801 0
0906 3 1 2 4 0904 0
0A10 1 2 2 2 0A14 0
0A1C 1 2 2 2 0A18 2
0B00 7 0 0 8 0B00 0
0C05 3 0 2 4 0C04 0
0D00 7 2 1 8 0D1C 0
0E00 5 2 1 6 0E14 0
0F30 7 1 2 8 0F3E 0
0F36 7 1 2 8 0F34 2
1000 0 0 0 1 1000 0
1104 6 2 1 7 111C 0
1200 2 1 0 3 1200 0
1301 7 1 1 8 130E 0
1408 1 2 0 2 1408 2
1504 3 2 2 4 1500 0
160C 3 2 2 4 1608 0
1700 7 2 2 8 171C 0

//--- verification/tb_axi_wr_master.sv
// --------------------------------------------------
// Testbench for axi_wr_master, commands from wr_cases.txt
// Slave side gives random ready and returns B out of order
// Run from the project root so the cases file is found
// --------------------------------------------------
`default_nettype none

module tb_axi_wr_master;

    localparam int WAIT_LIMIT = 2000;

    typedef struct packed {
        wr_ctrl_pkg::wr_cmd_t cmd;
        logic [3:0]           beats;
        axi_pkg::addr_t       last_addr;
        axi_pkg::resp_e       resp;
    } case_t;

    logic                 clk = 1'b0;
    logic                 rst_n = 1'b1;
    logic                 wr_en = 1'b0;
    wr_ctrl_pkg::wr_cmd_t wr_cmd = '0;
    logic                 wr_full;
    logic                 awvalid;
    logic                 awready = 1'b0;
    axi_pkg::aw_t         aw;
    logic                 wvalid;
    logic                 wready = 1'b0;
    axi_pkg::w_t          w;
    logic                 bvalid = 1'b0;
    logic                 bready;
    axi_pkg::b_t          b = '0;
    logic                 wr_resp_err;
    logic [3:0]           exp_beats = '0;
    axi_pkg::addr_t       exp_last_addr = '0;
    axi_pkg::resp_e       exp_resp = axi_pkg::RESP_OKAY;
    int                   errors;
    int                   checks;
    logic                 idle;
    logic                 full_seen;
    logic                 ooo_seen = 1'b0;
    case_t                cases[$];
    axi_pkg::resp_e       resp_q[$];
    axi_pkg::resp_e       resp_of [wr_ctrl_pkg::OST_DEPTH];
    wr_ctrl_pkg::slot_t   aw_ids[$];
    wr_ctrl_pkg::slot_t   done_ids[$];
    logic [31:0]          lcg_state = 32'd42470;
    int                   pick;
    int                   b_count = 0;
    int                   other_errs = 0;

    axi_wr_master i_dut (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .wr_cmd (wr_cmd), .wr_full (wr_full),
        .awvalid (awvalid), .awready (awready), .aw (aw),
        .wvalid (wvalid), .wready (wready), .w (w),
        .bvalid (bvalid), .bready (bready), .b (b), .wr_resp_err (wr_resp_err)
    );

    wr_master_checker i_checker (
        .clk (clk), .rst_n (rst_n), .wr_en (wr_en), .wr_cmd (wr_cmd), .wr_full (wr_full),
        .awvalid (awvalid), .awready (awready), .aw (aw),
        .wvalid (wvalid), .wready (wready), .w (w),
        .bvalid (bvalid), .bready (bready), .b (b), .wr_resp_err (wr_resp_err),
        .exp_beats (exp_beats), .exp_last_addr (exp_last_addr), .exp_resp (exp_resp),
        .errors (errors), .checks (checks), .idle (idle), .full_seen (full_seen)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // --------------------------------------------------
    // Slave model
    // --------------------------------------------------
    always @(posedge clk) begin
        if (rst_n) begin
            if (awvalid && awready) begin
                aw_ids.push_back(aw.id);
                if (resp_q.size() > 0) begin
                    resp_of[aw.id] = resp_q.pop_front();
                end
            end
            // Bursts finish in AW order
            if (wvalid && wready && w.last && aw_ids.size() > 0) begin
                done_ids.push_back(aw_ids.pop_front());
            end
            if (bvalid) begin
                b_count++;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            lcg_state = lcg_next(lcg_state);
            awready   = (lcg_state[21:20] != 2'd0);
            lcg_state = lcg_next(lcg_state);
            wready    = (lcg_state[21:20] != 2'd0);
            lcg_state = lcg_next(lcg_state);
            bvalid    = 1'b0;
            // Rare B lets the slots fill up and any finished burst may answer
            if (done_ids.size() > 0 && lcg_state[23:21] == 3'd0) begin
                pick   = int'(lcg_state[31:24]) % done_ids.size();
                b.id   = done_ids[pick];
                b.resp = resp_of[done_ids[pick]];
                done_ids.delete(pick);
                bvalid = 1'b1;
                if (pick != 0) begin
                    ooo_seen = 1'b1;
                end
            end
        end
    end

    // --------------------------------------------------
    // Command source
    // --------------------------------------------------
    task automatic load_cases();
        int    fd;
        int    n;
        int    a;
        int    l;
        int    s;
        int    bu;
        int    bt;
        int    la;
        int    r;
        string line;
        case_t c;
        fd = $fopen("verification/wr_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open verification/wr_cases.txt");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", a, l, s, bu, bt, la, r);
                if (n == 7) begin
                    c.cmd.addr  = axi_pkg::addr_t'(a);
                    c.cmd.len   = 8'(l);
                    c.cmd.size  = 3'(s);
                    c.cmd.burst = axi_pkg::burst_e'(bu[1:0]);
                    c.beats     = 4'(bt);
                    c.last_addr = axi_pkg::addr_t'(la);
                    c.resp      = axi_pkg::resp_e'(r[1:0]);
                    cases.push_back(c);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_commands();
        int waited;
        foreach (cases[i]) begin
            waited = 0;
            while (wr_full && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (wr_full) begin
                $display("Timeout: wr_full stayed high before command %0d", i);
                other_errs++;
                return;
            end
            wr_en         = 1'b1;
            wr_cmd        = cases[i].cmd;
            exp_beats     = cases[i].beats;
            exp_last_addr = cases[i].last_addr;
            exp_resp      = cases[i].resp;
            resp_q.push_back(cases[i].resp);
            @(negedge clk);
            wr_en = 1'b0;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (!(idle && b_count == cases.size()) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(idle && b_count == cases.size())) begin
            $display("Timeout: only %0d of %0d writes completed", b_count, cases.size());
            other_errs++;
        end else begin
            // Let the last wr_resp_err cycle be checked
            repeat (2) @(negedge clk);
        end
    endtask

    initial begin
        load_cases();
        #2;
        rst_n = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        if (cases.size() == 0) begin
            $display("No commands were read from the cases file");
            other_errs++;
        end else begin
            drive_commands();
        end
        if (other_errs == 0) begin
            wait_for_drain();
        end
        if (full_seen !== 1'b1) begin
            $display("wr_full never went high, the slots never filled");
            other_errs++;
        end
        if (ooo_seen !== 1'b1) begin
            $display("No B response was returned out of issue order");
            other_errs++;
        end
        $display("Checks %0d, check errors %0d, other errors %0d", checks, errors, other_errs);
        if (errors == 0 && other_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/wr_master_checker.sv
// --------------------------------------------------
// Reference model and scoreboard for axi_wr_master
// Expects W bursts in AW order and B only after wlast
// --------------------------------------------------
`default_nettype none

module wr_master_checker (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  wr_ctrl_pkg::wr_cmd_t wr_cmd,
    input  logic                 wr_full,
    input  logic                 awvalid,
    input  logic                 awready,
    input  axi_pkg::aw_t         aw,
    input  logic                 wvalid,
    input  logic                 wready,
    input  axi_pkg::w_t          w,
    input  logic                 bvalid,
    input  logic                 bready,
    input  axi_pkg::b_t          b,
    input  logic                 wr_resp_err,
    input  logic [3:0]           exp_beats,
    input  axi_pkg::addr_t       exp_last_addr,
    input  axi_pkg::resp_e       exp_resp,
    output int                   errors,
    output int                   checks,
    output logic                 idle,
    output logic                 full_seen
);

    typedef struct packed {
        wr_ctrl_pkg::wr_cmd_t cmd;
        wr_ctrl_pkg::slot_t   id;
        logic [3:0]           beats;
        axi_pkg::addr_t       last_addr;
        axi_pkg::resp_e       resp;
    } exp_t;

    exp_t                              acc_q[$];
    exp_t                              aw_q[$];
    exp_t                              cur;
    logic [wr_ctrl_pkg::OST_DEPTH-1:0] busy_m;
    logic [wr_ctrl_pkg::OST_DEPTH-1:0] done_m;
    axi_pkg::resp_e                    resp_m [wr_ctrl_pkg::OST_DEPTH];
    axi_pkg::addr_t                    exp_addr;
    logic                              err_exp;
    int                                beat_idx;

    // Beat n of a burst, from the AXI address rules
    function automatic axi_pkg::addr_t beat_addr(input wr_ctrl_pkg::wr_cmd_t c, input int n);
        int nbytes;
        int total;
        int start;
        int lower;
        int a;
        nbytes = 1 << c.size;
        total  = nbytes * (int'(c.len) + 1);
        start  = int'(c.addr);
        a      = start - (start % nbytes) + n * nbytes;
        if (c.burst == axi_pkg::BURST_WRAP) begin
            lower = (start / total) * total;
            if (a >= lower + total) begin
                a = a - total;
            end
        end
        if (n == 0 || c.burst == axi_pkg::BURST_FIXED) begin
            a = start;
        end
        return axi_pkg::addr_t'(a);
    endfunction

    function automatic wr_ctrl_pkg::slot_t lowest_free(
        input logic [wr_ctrl_pkg::OST_DEPTH-1:0] bz
    );
        logic               found;
        wr_ctrl_pkg::slot_t s;
        found = 1'b0;
        s     = '0;
        for (int i = 0; i < wr_ctrl_pkg::OST_DEPTH; i++) begin
            if (!bz[i] && !found) begin
                s     = wr_ctrl_pkg::slot_t'(i);
                found = 1'b1;
            end
        end
        return s;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0t signal %s got 0x%0h expected 0x%0h",
                     $time, name, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Checker problem at time %0t: %s", $time, msg);
    endtask

    // --------------------------------------------------
    // Per-cycle comparison, W then AW then accept then B
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rst_n) begin
            acc_q.delete();
            aw_q.delete();
            busy_m    = '0;
            done_m    = '0;
            err_exp   = 1'b0;
            beat_idx  = 0;
            errors    = 0;
            checks    = 0;
            full_seen = 1'b0;
            idle      = 1'b1;
        end else begin
            compare_field("wr_resp_err", wr_resp_err, err_exp);
            compare_field("wr_full", wr_full, &busy_m);
            compare_field("bready", bready, 1'b1);
            if (wr_full) begin
                full_seen = 1'b1;
            end
            err_exp = 1'b0;
            if (wvalid && wready) begin
                if (aw_q.size() == 0) begin
                    report_problem("W beat arrived with no AW issued before it");
                end else begin
                    cur      = aw_q[0];
                    exp_addr = beat_addr(cur.cmd, beat_idx);
                    compare_field("w.data", w.data,
                                  (32'(cur.id) << axi_pkg::ADDR_W) | 32'(exp_addr));
                    compare_field("w.strb", w.strb, {axi_pkg::STRB_W{1'b1}});
                    compare_field("w.last", w.last, beat_idx == int'(cur.cmd.len));
                    if (w.last || beat_idx == int'(cur.cmd.len)) begin
                        compare_field("beat count", beat_idx + 1, cur.beats);
                        compare_field("last beat address", exp_addr, cur.last_addr);
                        done_m[cur.id] = 1'b1;
                        resp_m[cur.id] = cur.resp;
                        void'(aw_q.pop_front());
                        beat_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            if (awvalid && awready) begin
                if (acc_q.size() == 0) begin
                    report_problem("AW handshake with no accepted command before it");
                end else begin
                    cur = acc_q.pop_front();
                    compare_field("aw.id", aw.id, cur.id);
                    compare_field("aw.addr", aw.addr, cur.cmd.addr);
                    compare_field("aw.len", aw.len, cur.cmd.len);
                    compare_field("aw.size", aw.size, cur.cmd.size);
                    compare_field("aw.burst", aw.burst, cur.cmd.burst);
                    aw_q.push_back(cur);
                end
            end
            // Slot choice uses the table as it was before this edge
            if (wr_en && !(&busy_m)) begin
                cur.cmd       = wr_cmd;
                cur.id        = lowest_free(busy_m);
                cur.beats     = exp_beats;
                cur.last_addr = exp_last_addr;
                cur.resp      = exp_resp;
                acc_q.push_back(cur);
                busy_m[cur.id] = 1'b1;
            end
            if (bvalid && bready) begin
                if (!done_m[b.id]) begin
                    report_problem($sformatf("B for slot %0d before its last W beat", b.id));
                end else begin
                    err_exp        = (resp_m[b.id] != axi_pkg::RESP_OKAY);
                    done_m[b.id]   = 1'b0;
                    busy_m[b.id]   = 1'b0;
                end
            end
            idle = (acc_q.size() == 0) && (aw_q.size() == 0) && (busy_m == '0);
        end
    end

endmodule

`default_nettype wire

//--- verification/wr_master_assert.sv
// --------------------------------------------------
// AXI handshake rules on the master's AW and W ports
// Bound into every axi_wr_master instance
// --------------------------------------------------
`default_nettype none

module wr_master_assert (
    input logic         clk,
    input logic         rst_n,
    input logic         awvalid,
    input logic         awready,
    input axi_pkg::aw_t aw,
    input logic         wvalid,
    input logic         wready,
    input axi_pkg::w_t  w
);

    // AW request held until accepted
    aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(aw))
        else $error("aw changed or awvalid dropped before awready");

    w_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(w))
        else $error("w changed or wvalid dropped before wready");

    // wlast only on a valid beat
    wlast_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        w.last |-> wvalid)
        else $error("wlast high without wvalid");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !awvalid && !wvalid)
        else $error("awvalid or wvalid high during reset");

endmodule

bind axi_wr_master wr_master_assert i_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .awvalid (awvalid),
    .awready (awready),
    .aw      (aw),
    .wvalid  (wvalid),
    .wready  (wready),
    .w       (w)
);

`default_nettype wire

//--- rtl/axi_wr_master.sv
// --------------------------------------------------
// AXI write master, up to four writes in flight
// bready is tied high, B may return in any order
// --------------------------------------------------
`default_nettype none

module axi_wr_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  wr_ctrl_pkg::wr_cmd_t wr_cmd,
    output logic                 wr_full,
    output logic                 awvalid,
    input  logic                 awready,
    output axi_pkg::aw_t         aw,
    output logic                 wvalid,
    input  logic                 wready,
    output axi_pkg::w_t          w,
    input  logic                 bvalid,
    output logic                 bready,
    input  axi_pkg::b_t          b,
    output logic                 wr_resp_err
);

    wr_ctrl_pkg::slot_t   issue_slot;
    logic                 issue_fire;
    wr_ctrl_pkg::slot_t   rd_slot;
    wr_ctrl_pkg::wr_cmd_t rd_cmd;
    wr_ctrl_pkg::slot_t   order_slot;
    logic                 order_valid;
    logic                 order_pop;
    logic                 beat_valid;
    wr_ctrl_pkg::beat_t   beat;
    logic                 beat_ready;

    wr_slot_table i_slot_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_cmd      (wr_cmd),
        .wr_full     (wr_full),
        .awvalid     (awvalid),
        .awready     (awready),
        .aw          (aw),
        .issue_slot  (issue_slot),
        .issue_fire  (issue_fire),
        .rd_slot     (rd_slot),
        .rd_cmd      (rd_cmd),
        .bvalid      (bvalid),
        .b           (b),
        .bready      (bready),
        .wr_resp_err (wr_resp_err)
    );

    // W bursts follow AW order
    wr_order_fifo i_data_order_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (issue_fire),
        .push_slot (issue_slot),
        .pop       (order_pop),
        .head_slot (order_slot),
        .not_empty (order_valid)
    );

    wr_burst_addr_gen i_burst_addr_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .order_slot  (order_slot),
        .order_valid (order_valid),
        .order_pop   (order_pop),
        .rd_slot     (rd_slot),
        .rd_cmd      (rd_cmd),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .beat_ready  (beat_ready)
    );

    wr_data_channel i_data_channel (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .beat_ready (beat_ready),
        .wvalid     (wvalid),
        .wready     (wready),
        .w          (w)
    );

endmodule

`default_nettype wire

//--- rtl/wr_data_channel.sv
// --------------------------------------------------
// W channel output register
// Data is zero pad, slot ID and beat address with all strobes set
// --------------------------------------------------
`default_nettype none

module wr_data_channel (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               beat_valid,
    input  wr_ctrl_pkg::beat_t beat,
    output logic               beat_ready,
    output logic               wvalid,
    input  logic               wready,
    output axi_pkg::w_t        w
);

    logic        load;
    axi_pkg::w_t w_next;

    // Free when empty or the held beat leaves this cycle
    assign beat_ready = !wvalid || wready;
    assign load       = beat_valid && beat_ready;

    always_comb begin
        w_next.data = {{(axi_pkg::DATA_W - axi_pkg::ID_W - axi_pkg::ADDR_W){1'b0}},
                       beat.slot, beat.addr};
        w_next.strb = '1;
        w_next.last = beat.last;
    end

    // --------------------------------------------------
    // Hold until handshake
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
            w      <= '0;
        end else if (load) begin
            wvalid <= 1'b1;
            w      <= w_next;
        end else if (wready) begin
            // wlast drops together with wvalid
            wvalid <= 1'b0;
            w.last <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/wr_burst_addr_gen.sv
// --------------------------------------------------
// Walks one burst at a time in AW order
// WRAP assumes len+1 of 2, 4 or 8 as AXI requires
// --------------------------------------------------
`default_nettype none

module wr_burst_addr_gen (
    input  logic                 clk,
    input  logic                 rst_n,
    input  wr_ctrl_pkg::slot_t   order_slot,
    input  logic                 order_valid,
    output logic                 order_pop,
    output wr_ctrl_pkg::slot_t   rd_slot,
    input  wr_ctrl_pkg::wr_cmd_t rd_cmd,
    output logic                 beat_valid,
    output wr_ctrl_pkg::beat_t   beat,
    input  logic                 beat_ready
);

    logic                                busy_r;
    wr_ctrl_pkg::slot_t                  slot_r;
    logic [wr_ctrl_pkg::BEAT_CNT_W-1:0]  beat_idx;
    logic [wr_ctrl_pkg::BEAT_CNT_W-1:0]  next_idx;
    axi_pkg::addr_t                      cur_addr;
    logic [wr_ctrl_pkg::MAX_SIZE:0]      num_bytes;
    axi_pkg::addr_t                      bytes_a;
    axi_pkg::addr_t                      aligned;
    axi_pkg::addr_t                      incr_addr;
    axi_pkg::addr_t                      wrap_mask;
    axi_pkg::addr_t                      wrap_addr;
    axi_pkg::addr_t                      next_addr;
    logic                                is_last;

    // New burst only when idle, one idle cycle between bursts
    assign order_pop  = !busy_r && order_valid;
    assign rd_slot    = busy_r ? slot_r : order_slot;
    assign beat_valid = busy_r;
    assign is_last    = (beat_idx == rd_cmd.len[wr_ctrl_pkg::BEAT_CNT_W-1:0]);
    assign next_idx   = beat_idx + 1'b1;

    always_comb begin
        beat.addr = cur_addr;
        beat.slot = slot_r;
        beat.last = is_last;
    end

    // --------------------------------------------------
    // Next beat address
    // --------------------------------------------------
    always_comb begin
        num_bytes = {{wr_ctrl_pkg::MAX_SIZE{1'b0}}, 1'b1} << rd_cmd.size;
        bytes_a   = axi_pkg::addr_t'(num_bytes);
        aligned   = rd_cmd.addr & ~(bytes_a - 1'b1);
        incr_addr = aligned + axi_pkg::addr_t'(next_idx) * bytes_a;
        // Window is (len+1) beats wide and aligned to itself
        wrap_mask = (axi_pkg::addr_t'(rd_cmd.len) + 1'b1) * bytes_a - 1'b1;
        wrap_addr = (rd_cmd.addr & ~wrap_mask) | (incr_addr & wrap_mask);
        case (rd_cmd.burst)
            axi_pkg::BURST_FIXED: next_addr = rd_cmd.addr;
            axi_pkg::BURST_WRAP:  next_addr = wrap_addr;
            default:              next_addr = incr_addr;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r   <= 1'b0;
            slot_r   <= '0;
            beat_idx <= '0;
            cur_addr <= '0;
        end else if (order_pop) begin
            busy_r   <= 1'b1;
            slot_r   <= order_slot;
            beat_idx <= '0;
            cur_addr <= rd_cmd.addr;
        end else if (beat_valid && beat_ready) begin
            if (is_last) begin
                busy_r <= 1'b0;
            end else begin
                beat_idx <= next_idx;
                cur_addr <= next_addr;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/wr_slot_table.sv
// --------------------------------------------------
// Outstanding slot table and AW channel
// Lowest free slot wins, AW goes out in acceptance order
// A slot stays busy until the B with its ID returns
// --------------------------------------------------
`default_nettype none

module wr_slot_table (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wr_en,
    input  wr_ctrl_pkg::wr_cmd_t wr_cmd,
    output logic                 wr_full,
    output logic                 awvalid,
    input  logic                 awready,
    output axi_pkg::aw_t         aw,
    output wr_ctrl_pkg::slot_t   issue_slot,
    output logic                 issue_fire,
    input  wr_ctrl_pkg::slot_t   rd_slot,
    output wr_ctrl_pkg::wr_cmd_t rd_cmd,
    input  logic                 bvalid,
    input  axi_pkg::b_t          b,
    output logic                 bready,
    output logic                 wr_resp_err
);

    logic [wr_ctrl_pkg::OST_DEPTH-1:0] busy;
    wr_ctrl_pkg::wr_cmd_t              cmd_mem [wr_ctrl_pkg::OST_DEPTH];
    wr_ctrl_pkg::slot_t                free_slot;
    wr_ctrl_pkg::wr_cmd_t              head_cmd;
    logic                              accept;
    logic                              b_fire;

    // --------------------------------------------------
    // Allocation
    // --------------------------------------------------
    assign wr_full = &busy;
    assign accept  = wr_en && !wr_full;

    // Scan downwards so the lowest free index is kept
    always_comb begin
        free_slot = '0;
        for (int i = wr_ctrl_pkg::OST_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = wr_ctrl_pkg::slot_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_mem[free_slot] <= wr_cmd;
        end
    end

    // Accept and release never hit the same slot in one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (accept) begin
                busy[free_slot] <= 1'b1;
            end
            if (b_fire) begin
                busy[b.id] <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // AW issue queue
    // --------------------------------------------------
    wr_order_fifo i_issue_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (accept),
        .push_slot (free_slot),
        .pop       (issue_fire),
        .head_slot (issue_slot),
        .not_empty (awvalid)
    );

    assign issue_fire = awvalid && awready;
    assign head_cmd   = cmd_mem[issue_slot];

    always_comb begin
        aw.id    = issue_slot;
        aw.addr  = head_cmd.addr;
        aw.len   = head_cmd.len;
        aw.size  = head_cmd.size;
        aw.burst = head_cmd.burst;
    end

    // Command lookup for the address generator
    assign rd_cmd = cmd_mem[rd_slot];

    // --------------------------------------------------
    // B response
    // --------------------------------------------------
    assign bready = 1'b1;
    assign b_fire = bvalid && bready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_resp_err <= 1'b0;
        end else begin
            wr_resp_err <= b_fire && (b.resp != axi_pkg::RESP_OKAY);
        end
    end

endmodule

`default_nettype wire

//--- rtl/wr_order_fifo.sv
// --------------------------------------------------
// Slot index FIFO, one entry per possible slot
// Never overflows since only allocated slots are pushed
// --------------------------------------------------
`default_nettype none

module wr_order_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  wr_ctrl_pkg::slot_t push_slot,
    input  logic               pop,
    output wr_ctrl_pkg::slot_t head_slot,
    output logic               not_empty
);

    wr_ctrl_pkg::slot_t          mem [wr_ctrl_pkg::OST_DEPTH];
    // Pointers wrap on their own, depth is a power of two
    logic [axi_pkg::ID_W-1:0]    wr_ptr;
    logic [axi_pkg::ID_W-1:0]    rd_ptr;
    logic [axi_pkg::ID_W:0]      count;
    logic                        do_pop;

    assign not_empty = (count != '0);
    assign head_slot = mem[rd_ptr];
    assign do_pop    = pop && not_empty;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_slot;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/wr_ctrl_pkg.sv
// --------------------------------------------------
// Write controller sizing and internal slot/beat types
// Commands must keep len within 0..7 and size within 0..2
// --------------------------------------------------
`default_nettype none

package wr_ctrl_pkg;

    // Slot count follows the AXI ID width, so slot == AWID
    localparam int OST_DEPTH     = 2 ** axi_pkg::ID_W;
    localparam int MAX_BURST_LEN = 8;
    localparam int BEAT_CNT_W    = $clog2(MAX_BURST_LEN);
    // Size code 2, four bytes per beat
    localparam int MAX_SIZE      = 2;

    typedef logic [axi_pkg::ID_W-1:0] slot_t;

    typedef struct packed {
        axi_pkg::addr_t            addr;
        logic [axi_pkg::LEN_W-1:0] len;
        logic [axi_pkg::SIZE_W-1:0] size;
        axi_pkg::burst_e           burst;
    } wr_cmd_t;

    typedef struct packed {
        axi_pkg::addr_t addr;
        slot_t          slot;
        logic           last;
    } beat_t;

endpackage

`default_nettype wire

//--- rtl/axi_pkg.sv
// --------------------------------------------------
// AXI4 write-side widths, encodings and channel payloads
// The ID width also fixes how many slots the master owns
// Size codes above 4 bytes are never produced here
// --------------------------------------------------
`default_nettype none

package axi_pkg;

    // --------------------------------------------------
    // Protocol widths
    // --------------------------------------------------
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int STRB_W  = DATA_W / 8;
    // One ID per outstanding slot
    localparam int ID_W    = 2;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef enum logic [BURST_W-1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_e;

    typedef enum logic [RESP_W-1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // --------------------------------------------------
    // Channel payloads
    // --------------------------------------------------
    typedef struct packed {
        logic [ID_W-1:0]   id;
        addr_t             addr;
        logic [LEN_W-1:0]  len;
        logic [SIZE_W-1:0] size;
        burst_e            burst;
    } aw_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_e           resp;
    } b_t;

endpackage

`default_nettype wire
